/* flist.f */
spi_pkg.sv
spi_shift_engine.sv
spi_cs_sequencer.sv
spi_tx_queue.sv
spi_master_top.sv
tb_spi_slave_model.sv
tb_spi_master.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SPI master testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_spi_master -f flist.f -o sim_spi
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_spi > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "STATUS: PASS" sim.log; then
    exit 0
fi
exit 1

/* spi_cs_sequencer.sv */
`timescale 1ns/1ps

module spi_cs_sequencer (
    input  logic               i_Clk,
    input  logic               i_Rst_L,

    // Requests from the queue
    input  spi_pkg::tx_req_t   i_Req,
    input  logic               i_Req_Valid,  // One-cycle strobe
    output logic               o_TX_Ready,   // Level forced low during strobe

    // Received bytes
    output spi_pkg::rx_beat_t  o_Rx,
    output logic               o_Rx_Valid,

    // SPI pins
    input  logic               i_SPI_MISO,
    output spi_pkg::spi_pins_t o_Spi
);

    import spi_pkg::*;

    cs_state_e          r_state;
    logic               r_cs_n;
    logic [COUNT_W-1:0] r_tx_count;  // Bytes left after the current one
    logic [COUNT_W-1:0] r_rx_index;  // Position of next RX byte in frame
    logic [GAP_W-1:0]   r_gap_cnt;

    logic       w_eng_ready;
    logic       w_rx_dv;
    logic [7:0] w_rx_byte;
    logic       w_sclk;
    logic       w_mosi;

    // Bit-level engine takes the forwarded strobe directly
    spi_shift_engine u_engine (
        .i_Clk      (i_Clk),
        .i_Rst_L    (i_Rst_L),
        .i_TX_Byte  (i_Req.data),
        .i_TX_DV    (i_Req_Valid),
        .o_TX_Ready (w_eng_ready),
        .o_RX_DV    (w_rx_dv),
        .o_RX_Byte  (w_rx_byte),
        .o_SPI_Clk  (w_sclk),
        .i_SPI_MISO (i_SPI_MISO),
        .o_SPI_MOSI (w_mosi)
    );

    // Chip-select FSM
    always_ff @(posedge i_Clk or negedge i_Rst_L) begin
        if (!i_Rst_L) begin
            r_state    <= CS_IDLE;
            r_cs_n     <= 1'b1;
            r_tx_count <= '0;
            r_gap_cnt  <= GAP_W'(CS_INACTIVE_CLKS);
        end else begin
            case (r_state)
                CS_IDLE: begin
                    if (i_Req_Valid) begin
                        r_tx_count <= i_Req.count - 1'b1;  // First byte already going
                        r_cs_n     <= 1'b0;
                        r_state    <= CS_TRANSFER;
                    end
                end

                CS_TRANSFER: begin
                    if (w_eng_ready) begin
                        if (r_tx_count != '0) begin
                            // CS held low until next byte shows up
                            if (i_Req_Valid) begin
                                r_tx_count <= r_tx_count - 1'b1;
                            end
                        end else begin
                            r_cs_n    <= 1'b1;  // Frame done
                            r_gap_cnt <= GAP_W'(CS_INACTIVE_CLKS);
                            r_state   <= CS_GAP;
                        end
                    end
                end

                CS_GAP: begin
                    if (r_gap_cnt != '0) begin
                        r_gap_cnt <= r_gap_cnt - 1'b1;
                    end else begin
                        r_state <= CS_IDLE;
                    end
                end

                default: begin
                    r_cs_n  <= 1'b1;
                    r_state <= CS_IDLE;
                end
            endcase
        end
    end

    // RX index restarts every frame
    always_ff @(posedge i_Clk or negedge i_Rst_L) begin
        if (!i_Rst_L) begin
            r_rx_index <= '0;
        end else if (r_cs_n) begin
            r_rx_index <= '0;
        end else if (w_rx_dv) begin
            r_rx_index <= r_rx_index + 1'b1;
        end
    end

    // Idle, or mid-frame with engine free and bytes left, and no strobe in flight
    assign o_TX_Ready = ((r_state == CS_IDLE) ||
                         (r_state == CS_TRANSFER && w_eng_ready && r_tx_count != '0))
                        && !i_Req_Valid;

    assign o_Rx.index = r_rx_index;
    assign o_Rx.data  = w_rx_byte;
    assign o_Rx_Valid = w_rx_dv;

    assign o_Spi.sclk = w_sclk;
    assign o_Spi.mosi = w_mosi;
    assign o_Spi.cs_n = r_cs_n;

    // Queue only issues after seeing ready
    a_req_after_ready : assert property (
        @(posedge i_Clk) disable iff (!i_Rst_L)
        i_Req_Valid |-> $past(o_TX_Ready)
    );

    // Frame opening needs a nonzero burst length
    a_count_nonzero : assert property (
        @(posedge i_Clk) disable iff (!i_Rst_L)
        (i_Req_Valid && r_state == CS_IDLE) |-> (i_Req.count != '0)
    );

endmodule

/* spi_master_top.sv */
`timescale 1ns/1ps

module spi_master_top (
    input  logic               i_Clk,
    input  logic               i_Rst_L,

    // Host request port
    input  logic               i_Wr_Valid,
    input  spi_pkg::tx_req_t   i_Wr_Req,
    output logic               o_Queue_Full,

    // Received bytes as one pulse each
    output spi_pkg::rx_beat_t  o_Rx,
    output logic               o_Rx_Valid,

    // SPI pins
    input  logic               i_SPI_MISO,
    output spi_pkg::spi_pins_t o_Spi
);

    import spi_pkg::*;

    tx_req_t w_req;        // Popped request
    logic    w_req_valid;  // Strobe into sequencer
    logic    w_tx_ready;   // Sequencer can take a byte

    // Request buffer
    spi_tx_queue u_queue (
        .i_Clk        (i_Clk),
        .i_Rst_L      (i_Rst_L),
        .i_Wr_Valid   (i_Wr_Valid),
        .i_Wr_Req     (i_Wr_Req),
        .o_Queue_Full (o_Queue_Full),
        .i_Rd_Ready   (w_tx_ready),
        .o_Req        (w_req),
        .o_Req_Valid  (w_req_valid)
    );

    // CS framing plus shift engine
    spi_cs_sequencer u_seq (
        .i_Clk        (i_Clk),
        .i_Rst_L      (i_Rst_L),
        .i_Req        (w_req),
        .i_Req_Valid  (w_req_valid),
        .o_TX_Ready   (w_tx_ready),
        .o_Rx         (o_Rx),
        .o_Rx_Valid   (o_Rx_Valid),
        .i_SPI_MISO   (i_SPI_MISO),
        .o_Spi        (o_Spi)
    );

endmodule

/* spi_pkg.sv */
package spi_pkg;

    // SPI timing and framing constants
    localparam int SPI_MODE          = 0;  // Mode 0 keeps CPOL and CPHA low
    localparam int CLKS_PER_HALF_BIT = 2;  // System clocks per SCLK half period
    localparam int MAX_BYTES_PER_CS  = 4;  // Longest burst under one CS low
    localparam int CS_INACTIVE_CLKS  = 2;  // Min CS high time between frames
    localparam int TX_QUEUE_DEPTH    = 8;  // Host request slots

    // Derived from the mode number
    localparam logic SPI_CPOL = (SPI_MODE == 2) || (SPI_MODE == 3);  // SCLK idle level
    localparam logic SPI_CPHA = (SPI_MODE == 1) || (SPI_MODE == 3);  // Capture on trailing edge

    // Derived widths
    localparam int COUNT_W        = $clog2(MAX_BYTES_PER_CS + 1);
    localparam int EDGES_PER_BYTE = 16;                          // Two SCLK edges per bit
    localparam int EDGE_W         = $clog2(EDGES_PER_BYTE + 1);
    localparam int HALF_CNT_W     = $clog2(CLKS_PER_HALF_BIT + 1);
    localparam int GAP_W          = $clog2(CS_INACTIVE_CLKS + 1);
    localparam int QUEUE_PTR_W    = $clog2(TX_QUEUE_DEPTH);
    localparam int QUEUE_CNT_W    = $clog2(TX_QUEUE_DEPTH + 1);

    // One host request
    typedef struct packed {
        logic [COUNT_W-1:0] count;  // Bytes in frame read only on first byte
        logic [7:0]         data;   // Byte for MOSI
    } tx_req_t;

    // One received byte and its place in the frame
    typedef struct packed {
        logic [COUNT_W-1:0] index;
        logic [7:0]         data;
    } rx_beat_t;

    // Outgoing SPI pins
    typedef struct packed {
        logic sclk;
        logic mosi;
        logic cs_n;  // Active low
    } spi_pins_t;

    typedef enum logic [1:0] {CS_IDLE, CS_TRANSFER, CS_GAP} cs_state_e;

    typedef enum logic {SH_IDLE, SH_SHIFT} shift_state_e;

endpackage

/* spi_shift_engine.sv */
`timescale 1ns/1ps

module spi_shift_engine (
    input  logic       i_Clk,
    input  logic       i_Rst_L,

    // Byte request from the sequencer
    input  logic [7:0] i_TX_Byte,
    input  logic       i_TX_DV,      // One-cycle strobe with i_TX_Byte
    output logic       o_TX_Ready,   // High while idle

    // Received byte
    output logic       o_RX_DV,      // One-cycle pulse after last edge
    output logic [7:0] o_RX_Byte,

    // SPI lines
    output logic       o_SPI_Clk,
    input  logic       i_SPI_MISO,
    output logic       o_SPI_MOSI
);

    import spi_pkg::*;

    shift_state_e          r_state;
    logic [HALF_CNT_W-1:0] r_half_cnt;    // Clocks within current half bit
    logic [EDGE_W-1:0]     r_edges_left;  // SCLK edges still to produce
    logic                  r_sclk;
    logic                  r_mosi;
    logic [7:0]            r_tx_shift;    // Bits not yet on MOSI
    logic [7:0]            r_rx_shift;    // Bits gathered from MISO

    logic w_half_done;
    logic w_edge;
    logic w_leading;
    logic w_trailing;
    logic w_shift_edge;
    logic w_capture_edge;

    // Edge decode
    assign w_half_done = (r_half_cnt == HALF_CNT_W'(CLKS_PER_HALF_BIT - 1));
    assign w_edge      = (r_state == SH_SHIFT) && (r_edges_left != '0) && w_half_done;

    // Leading edge moves SCLK away from its idle level
    assign w_leading  = w_edge && (r_sclk == SPI_CPOL);
    assign w_trailing = w_edge && (r_sclk != SPI_CPOL);

    // CPHA picks which edge launches and which samples
    assign w_shift_edge   = SPI_CPHA ? w_leading  : w_trailing;
    assign w_capture_edge = SPI_CPHA ? w_trailing : w_leading;

    // Byte FSM with half-bit divider and edge counter
    always_ff @(posedge i_Clk or negedge i_Rst_L) begin
        if (!i_Rst_L) begin
            r_state      <= SH_IDLE;
            r_half_cnt   <= '0;
            r_edges_left <= '0;
            r_sclk       <= SPI_CPOL;  // Idle level
            o_RX_DV      <= 1'b0;
        end else begin
            o_RX_DV <= 1'b0;  // Pulse by default off
            case (r_state)
                SH_IDLE: begin
                    if (i_TX_DV) begin
                        r_state      <= SH_SHIFT;
                        r_half_cnt   <= '0;
                        r_edges_left <= EDGE_W'(EDGES_PER_BYTE);
                    end
                end

                SH_SHIFT: begin
                    if (r_edges_left == '0) begin
                        // Last edge went out on the previous clock
                        r_state <= SH_IDLE;
                        o_RX_DV <= 1'b1;
                    end else if (w_half_done) begin
                        r_half_cnt   <= '0;
                        r_sclk       <= ~r_sclk;            // Next SCLK edge
                        r_edges_left <= r_edges_left - 1'b1;
                    end else begin
                        r_half_cnt <= r_half_cnt + 1'b1;
                    end
                end

                default: r_state <= SH_IDLE;
            endcase
        end
    end

    // MOSI launch
    always_ff @(posedge i_Clk or negedge i_Rst_L) begin
        if (!i_Rst_L) begin
            r_mosi <= 1'b0;
        end else if (r_state == SH_IDLE && i_TX_DV) begin
            if (!SPI_CPHA) begin
                r_mosi <= i_TX_Byte[7];  // MSB must be set up before first edge
            end
        end else if (w_shift_edge) begin
            r_mosi <= r_tx_shift[7];
        end
    end

    // Transmit shift register sends MSB first
    always_ff @(posedge i_Clk) begin
        if (r_state == SH_IDLE && i_TX_DV) begin
            if (SPI_CPHA) begin
                r_tx_shift <= i_TX_Byte;
            end else begin
                r_tx_shift <= {i_TX_Byte[6:0], 1'b0};  // Bit 7 already on MOSI
            end
        end else if (w_shift_edge) begin
            r_tx_shift <= {r_tx_shift[6:0], 1'b0};
        end
    end

    // MISO sampled on capture edge
    always_ff @(posedge i_Clk) begin
        if (w_capture_edge) begin
            r_rx_shift <= {r_rx_shift[6:0], i_SPI_MISO};
        end
    end

    assign o_TX_Ready = (r_state == SH_IDLE);
    assign o_RX_Byte  = r_rx_shift;  // Complete when o_RX_DV pulses
    assign o_SPI_Clk  = r_sclk;
    assign o_SPI_MOSI = r_mosi;

    // RX valid is a single-cycle pulse
    a_rx_dv_pulse : assert property (
        @(posedge i_Clk) disable iff (!i_Rst_L)
        o_RX_DV |=> !o_RX_DV
    );

    // Sequencer must not strobe mid-byte
    a_no_strobe_busy : assert property (
        @(posedge i_Clk) disable iff (!i_Rst_L)
        i_TX_DV |-> (r_state == SH_IDLE)
    );

endmodule

/* spi_tx_queue.sv */
`timescale 1ns/1ps

module spi_tx_queue (
    input  logic             i_Clk,
    input  logic             i_Rst_L,

    // Host write side
    input  logic             i_Wr_Valid,
    input  spi_pkg::tx_req_t i_Wr_Req,
    output logic             o_Queue_Full,

    // Sequencer read side
    input  logic             i_Rd_Ready,   // Sequencer ready level
    output spi_pkg::tx_req_t o_Req,
    output logic             o_Req_Valid   // One-cycle pulse per pop
);

    import spi_pkg::*;

    tx_req_t                r_mem [TX_QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] r_wr_ptr;
    logic [QUEUE_PTR_W-1:0] r_rd_ptr;
    logic [QUEUE_CNT_W-1:0] r_count;  // Occupancy

    logic w_push;
    logic w_pop;
    logic w_empty;

    assign o_Queue_Full = (r_count == QUEUE_CNT_W'(TX_QUEUE_DEPTH));
    assign w_empty      = (r_count == '0);
    assign w_push       = i_Wr_Valid && !o_Queue_Full;  // Full write dropped
    assign w_pop        = i_Rd_Ready && !w_empty && !o_Req_Valid;

    // Pointers and occupancy
    always_ff @(posedge i_Clk or negedge i_Rst_L) begin
        if (!i_Rst_L) begin
            r_wr_ptr    <= '0;
            r_rd_ptr    <= '0;
            r_count     <= '0;
            o_Req_Valid <= 1'b0;
        end else begin
            o_Req_Valid <= w_pop;  // Presented the clock after the pop
            if (w_push) begin
                r_wr_ptr <= (r_wr_ptr == QUEUE_PTR_W'(TX_QUEUE_DEPTH - 1)) ? '0
                                                                          : r_wr_ptr + 1'b1;
            end
            if (w_pop) begin
                r_rd_ptr <= (r_rd_ptr == QUEUE_PTR_W'(TX_QUEUE_DEPTH - 1)) ? '0
                                                                          : r_rd_ptr + 1'b1;
            end
            if (w_push && !w_pop) begin
                r_count <= r_count + 1'b1;
            end else if (w_pop && !w_push) begin
                r_count <= r_count - 1'b1;
            end
        end
    end

    // Storage and output register
    always_ff @(posedge i_Clk) begin
        if (w_push) begin
            r_mem[r_wr_ptr] <= i_Wr_Req;
        end
        if (w_pop) begin
            o_Req <= r_mem[r_rd_ptr];
        end
    end

    a_no_overflow : assert property (
        @(posedge i_Clk) disable iff (!i_Rst_L)
        r_count <= QUEUE_CNT_W'(TX_QUEUE_DEPTH)
    );

endmodule

/* tb_spi_master.sv */
`timescale 1ns/1ps

module tb_spi_master;

    import spi_pkg::*;

    typedef logic [7:0] byte_q_t [$];

    localparam int BYTE_CLKS     = 16 * CLKS_PER_HALF_BIT + CS_INACTIVE_CLKS + 8;  // With CS slack
    localparam int RAND_FRAMES   = 6;
    localparam int TOTAL_BYTES   = 1 + 4 + 5 + (TX_QUEUE_DEPTH + 2)
                                   + RAND_FRAMES * MAX_BYTES_PER_CS;
    localparam int WATCHDOG_CLKS = TOTAL_BYTES * BYTE_CLKS + 400;

    logic      clk = 1'b0;
    logic      rst_l;
    logic      wr_valid;
    tx_req_t   wr_req;
    logic      queue_full;
    rx_beat_t  rx;
    logic      rx_valid;
    logic      miso;
    spi_pins_t spi;
    int        slave_frames;
    int        slave_gap;

    rx_beat_t    rx_q [$];       // Beats seen on o_Rx
    rx_beat_t    exp_beats [$];
    logic [7:0]  exp_mosi [$];
    int          mosi_base;      // Slave log size at test start
    int          frame_base;
    int          errors = 0;
    int          test_errors;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic [31:0] lcg_state = 32'h5f1b;

    always #10 clk = ~clk;  // 20 ns period

    spi_master_top dut (
        .i_Clk        (clk),
        .i_Rst_L      (rst_l),
        .i_Wr_Valid   (wr_valid),
        .i_Wr_Req     (wr_req),
        .o_Queue_Full (queue_full),
        .o_Rx         (rx),
        .o_Rx_Valid   (rx_valid),
        .i_SPI_MISO   (miso),
        .o_Spi        (spi)
    );

    tb_spi_slave_model u_slave (
        .i_Clk      (clk),
        .i_Sclk     (spi.sclk),
        .i_Mosi     (spi.mosi),
        .i_Cs_N     (spi.cs_n),
        .o_Miso     (miso),
        .o_Frames   (slave_frames),
        .o_Last_Gap (slave_gap)
    );

    // Beats taken mid-cycle
    always @(negedge clk) begin
        if (rst_l && rx_valid) begin
            rx_q.push_back(rx);
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_beat(input string name, input rx_beat_t exp, input rx_beat_t act);
        if (exp !== act) begin
            $display("Fail %s: expected index %0d data %h, actual index %0d data %h",
                     name, exp.index, exp.data, act.index, act.data);
            errors++;
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            $display("Fail %s: expected MOSI byte %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input string name, input logic ok, input string what);
        if (ok !== 1'b1) begin
            $display("Error in %s: %s", name, what);
            errors++;
        end
    endtask

    task automatic start_test();
        rx_q.delete();
        exp_beats.delete();
        exp_mosi.delete();
        test_errors = errors;
        mosi_base   = u_slave.mosi_log.size();
        frame_base  = slave_frames;
    endtask

    // One burst of consecutive writes with expected beats from the slave rule
    task automatic queue_frame(input byte_q_t bytes);
        rx_beat_t beat;
        foreach (bytes[i]) begin
            beat.index = COUNT_W'(i);
            if (i == 0) begin
                beat.data = 8'hA5;
            end else begin
                beat.data = bytes[i-1];  // Echo of previous MOSI byte
            end
            exp_beats.push_back(beat);
            exp_mosi.push_back(bytes[i]);
            @(negedge clk);
            wr_valid     = 1'b1;
            wr_req.count = COUNT_W'(bytes.size());
            wr_req.data  = bytes[i];
        end
        @(negedge clk);
        wr_valid = 1'b0;
    endtask

    task automatic wait_beats(input string name, input int n);
        int waited;
        waited = 0;
        while (rx_q.size() < n && waited < n * BYTE_CLKS + 50) begin
            @(negedge clk);
            waited++;
        end
        check_true(name, rx_q.size() >= n, "timed out waiting for received bytes");
    endtask

    task automatic finish_test(input string name, input int frames, input int min_gap);
        wait_beats(name, exp_beats.size());
        repeat (CS_INACTIVE_CLKS + 4) @(negedge clk);  // CS back high
        check_true(name, rx_q.size() == exp_beats.size(), "wrong number of received bytes");
        foreach (exp_beats[i]) begin
            if (i < rx_q.size()) begin
                check_beat(name, exp_beats[i], rx_q[i]);
            end
        end
        check_true(name, u_slave.mosi_log.size() - mosi_base == exp_mosi.size(),
                   "slave captured a wrong number of MOSI bytes");
        foreach (exp_mosi[i]) begin
            if (mosi_base + i < u_slave.mosi_log.size()) begin
                check_byte(name, exp_mosi[i], u_slave.mosi_log[mosi_base + i]);
            end
        end
        check_true(name, slave_frames - frame_base == frames, "wrong number of chip-select frames");
        if (min_gap > 0) begin
            check_true(name, slave_gap >= min_gap, "chip-select high gap too short");
        end
        if (errors == test_errors) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - test_errors);
        end
    endtask

    task automatic test_reset();
        start_test();
        @(negedge clk);
        check_true("reset", spi.cs_n === 1'b1, "chip-select not high after reset");
        check_true("reset", spi.sclk === SPI_CPOL, "SCLK not at idle level after reset");
        check_true("reset", rx_valid === 1'b0, "o_Rx_Valid high after reset");
        check_true("reset", queue_full === 1'b0, "o_Queue_Full high after reset");
        finish_test("reset", 0, 0);
    endtask

    task automatic test_single_byte();
        byte_q_t bytes;
        start_test();
        bytes.push_back(8'h3C);
        queue_frame(bytes);
        finish_test("single_byte", 1, 0);
    endtask

    task automatic test_burst_four();
        byte_q_t bytes;
        start_test();
        bytes.push_back(8'hC3);
        bytes.push_back(8'h5A);
        bytes.push_back(8'h0F);
        bytes.push_back(8'hE1);
        queue_frame(bytes);
        finish_test("burst_four", 1, 0);
    endtask

    // Second burst queued behind the first so the index restarts at 0
    task automatic test_back_to_back();
        byte_q_t first;
        byte_q_t second;
        start_test();
        first.push_back(8'h81);
        first.push_back(8'h42);
        first.push_back(8'h24);
        second.push_back(8'h99);
        second.push_back(8'h66);
        queue_frame(first);
        queue_frame(second);
        finish_test("back_to_back", 2, CS_INACTIVE_CLKS + 1);
    endtask

    // Idle sequencer takes the first request so depth plus one writes fit
    task automatic test_queue_full();
        rx_beat_t    beat;
        logic [31:0] rnd;
        start_test();
        beat.index = '0;
        beat.data  = 8'hA5;
        for (int i = 0; i < TX_QUEUE_DEPTH + 2; i++) begin
            rnd = lcg_next();
            @(negedge clk);
            wr_valid     = 1'b1;
            wr_req.count = COUNT_W'(1);
            wr_req.data  = rnd[23:16];
            if (i <= TX_QUEUE_DEPTH) begin
                check_true("queue_full", queue_full === 1'b0,
                           "queue reported full before it held its depth");
                exp_beats.push_back(beat);
                exp_mosi.push_back(rnd[23:16]);
            end else begin
                check_true("queue_full", queue_full === 1'b1,
                           "queue not full after depth plus one writes");
            end
        end
        @(negedge clk);
        wr_valid = 1'b0;
        finish_test("queue_full", TX_QUEUE_DEPTH + 1, 0);
    endtask

    task automatic test_random_bursts();
        byte_q_t     bytes;
        logic [31:0] rnd;
        int          len;
        start_test();
        for (int f = 0; f < RAND_FRAMES; f++) begin
            bytes.delete();
            rnd = lcg_next();
            len = 1 + int'(rnd >> 16) % MAX_BYTES_PER_CS;
            for (int i = 0; i < len; i++) begin
                rnd = lcg_next();
                bytes.push_back(rnd[23:16]);
            end
            queue_frame(bytes);
            wait_beats("random_bursts", exp_beats.size());  // Keeps the queue from overflowing
        end
        finish_test("random_bursts", RAND_FRAMES, CS_INACTIVE_CLKS + 1);
    endtask

    initial begin
        rst_l    = 1'b0;
        wr_valid = 1'b0;
        wr_req   = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_l = 1'b1;
        test_reset();
        test_single_byte();
        test_burst_four();
        test_back_to_back();
        test_queue_full();
        test_random_bursts();
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the byte budget of all tests
    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk);
        $display("Timeout: tests did not finish within %0d clocks", WATCHDOG_CLKS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* tb_spi_slave_model.sv */
`timescale 1ns/1ps

module tb_spi_slave_model (
    input  logic i_Clk,
    input  logic i_Sclk,
    input  logic i_Mosi,
    input  logic i_Cs_N,
    output logic o_Miso,
    output int   o_Frames,    // CS falling edges so far
    output int   o_Last_Gap   // CS high clocks ahead of latest frame
);

    logic [7:0] mosi_log [$];  // Every MOSI byte in order
    logic [7:0] r_rx_shift;
    logic [7:0] r_tx_byte;     // Byte going out on MISO
    int         r_bit_cnt;     // Bits of current byte already sampled
    int         r_high_clks;

    initial begin
        o_Miso      = 1'b0;
        o_Frames    = 0;
        o_Last_Gap  = 0;
        r_rx_shift  = '0;
        r_tx_byte   = 8'hA5;
        r_bit_cnt   = 0;
        r_high_clks = 0;
    end

    // Clocks with CS high since it last rose
    always @(posedge i_Clk) begin
        if (i_Cs_N === 1'b1) begin
            r_high_clks = r_high_clks + 1;
        end else begin
            r_high_clks = 0;
        end
    end

    // Frame start loads the fixed first reply byte
    always @(negedge i_Cs_N) begin
        o_Frames   = o_Frames + 1;
        o_Last_Gap = r_high_clks;
        r_bit_cnt  = 0;
        r_tx_byte  = 8'hA5;
        o_Miso     = r_tx_byte[7];  // MSB ready before first rising edge
    end

    // Mode 0 sample on rising SCLK
    always @(posedge i_Sclk) begin
        if (i_Cs_N === 1'b0) begin
            r_rx_shift = {r_rx_shift[6:0], i_Mosi};
            r_bit_cnt  = r_bit_cnt + 1;
            if (r_bit_cnt == 8) begin
                mosi_log.push_back(r_rx_shift);
                r_tx_byte = r_rx_shift;  // Echoed on the next byte
                r_bit_cnt = 0;
            end
        end
    end

    // Next MISO bit on falling SCLK
    always @(negedge i_Sclk) begin
        if (i_Cs_N === 1'b0) begin
            o_Miso = r_tx_byte[7 - r_bit_cnt];
        end
    end

endmodule
